/* common/msp430_per_pkg.sv */
/*
 * Peripheral bus package
 * Bus field types, byte-lane merge and the block address map
 */
`default_nettype none

package msp430_per_pkg;

  typedef logic [13:0] per_addr_t;  // Word address, byte address / 2
  typedef logic [15:0] per_data_t;  // Bus data
  typedef logic [1:0]  per_we_t;    // Byte-lane write enable
  typedef logic [3:0]  blk_sel_t;   // One-hot block select

  localparam int SEL_GPIO  = 0;     // Select bit positions
  localparam int SEL_TIMER = 1;
  localparam int SEL_DACX  = 2;
  localparam int SEL_DACY  = 3;

  // ================================================
  // Address map, word addresses
  // ================================================
  localparam per_addr_t GPIO_BASE  = per_addr_t'(16'h0020 >> 1);
  localparam per_addr_t GPIO_SPAN  = per_addr_t'(8);
  localparam per_addr_t TIMER_BASE = per_addr_t'(16'h0160 >> 1);
  localparam per_addr_t TIMER_SPAN = per_addr_t'(16);
  localparam per_addr_t DAC_SPAN   = per_addr_t'(4);    // Same for both channels
  localparam per_addr_t DACX_BASE  = per_addr_t'(16'h0190 >> 1);
  localparam per_addr_t DACX_SPAN  = DAC_SPAN;
  localparam per_addr_t DACY_BASE  = per_addr_t'(16'h0198 >> 1);
  localparam per_addr_t DACY_SPAN  = DAC_SPAN;

  // Apply a write to a register, one byte per set lane
  function automatic per_data_t byte_merge(per_data_t cur, per_data_t wdata, per_we_t we);
    per_data_t res;
    res = cur;
    if (we[0]) res[7:0] = wdata[7:0];    // Low lane
    if (we[1]) res[15:8] = wdata[15:8];  // High lane
    return res;
  endfunction

endpackage

`default_nettype wire

/* common/msp430_dev_pkg.sv */
/*
 * Peripheral device package
 * Register offsets, bit positions, interrupt slots and FSM states
 */
`default_nettype none

package msp430_dev_pkg;

  typedef logic [7:0]  port_t;      // One 8-bit port
  typedef logic [3:0]  reg_off_t;   // Word offset inside a block
  typedef logic [13:0] irq_vec_t;   // Maskable interrupt lines

  // ================================================
  // Register offsets
  // ================================================
  localparam reg_off_t P1IN     = 4'd0;  // GPIO
  localparam reg_off_t P1IE     = 4'd1;
  localparam reg_off_t P1IFG    = 4'd2;
  localparam reg_off_t P2OUT    = 4'd4;
  localparam reg_off_t P2DIR    = 4'd5;
  localparam reg_off_t TACTL    = 4'd0;  // Timer A
  localparam reg_off_t TACCTL0  = 4'd1;
  localparam reg_off_t TAR      = 4'd8;
  localparam reg_off_t TACCR0   = 4'd9;
  localparam reg_off_t DAC_VAL  = 4'd0;  // DAC channel
  localparam reg_off_t DAC_STAT = 4'd1;

  localparam int TACTL_RUN     = 0;      // Bit positions
  localparam int TACCTL0_CCIE  = 4;
  localparam int TACCTL0_CCIFG = 0;
  localparam int DAC_STAT_BUSY = 0;

  localparam int IRQ_PORT1 = 0;          // Vector slots
  localparam int IRQ_TA1   = 4;
  localparam int IRQ_TA0   = 5;

  // ================================================
  // DAC serializer
  // ================================================
  localparam int SCLK_DIV  = 1;          // Half period is SCLK_DIV+1 mclk
  localparam int DAC_BITS  = 16;
  localparam int DIV_W     = (SCLK_DIV > 0) ? $clog2(SCLK_DIV + 1) : 1;
  localparam int BIT_CNT_W = $clog2(DAC_BITS + 1);

  typedef logic [DIV_W-1:0]     div_cnt_t;
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

  typedef enum logic [1:0] {IDLE, SHIFT, DONE} spi_state_e;

endpackage

`default_nettype wire

/* common/per_if.sv */
/*
 * Peripheral bus
 * Single-cycle strobe with byte-lane write enables
 */
`timescale 1ns/10ps
`default_nettype none

interface per_if;
  import msp430_per_pkg::*;

  per_addr_t addr;  // Word address
  per_data_t din;   // Write data
  per_we_t   we;    // Nonzero means write
  logic      en;    // Access strobe

  // Bus master side
  modport ctrl  (output addr, output din, output we, output en);

  // Decode and peripherals
  modport slave (input addr, input din, input we, input en);

endinterface

`default_nettype wire

/* source/per_decode.sv */
/*
 * Peripheral address decode
 * One select per block, qualified by the bus strobe
 */
`timescale 1ns/10ps
`default_nettype none

module per_decode (
  per_if.slave                     bus,
  output msp430_per_pkg::blk_sel_t sel
);
  import msp430_per_pkg::*;

  logic hit_gpio, hit_timer, hit_dacx, hit_dacy;

  // ================================================
  // Range compare against the address map
  // ================================================
  assign hit_gpio  = (bus.addr >= GPIO_BASE) &&
                     (bus.addr < GPIO_BASE + GPIO_SPAN);
  assign hit_timer = (bus.addr >= TIMER_BASE) &&
                     (bus.addr < TIMER_BASE + TIMER_SPAN);
  assign hit_dacx  = (bus.addr >= DACX_BASE) &&
                     (bus.addr < DACX_BASE + DACX_SPAN);
  assign hit_dacy  = (bus.addr >= DACY_BASE) &&   // Own base, not shared with X
                     (bus.addr < DACY_BASE + DACY_SPAN);

  always_comb begin
    sel            = '0;
    sel[SEL_GPIO]  = bus.en & hit_gpio;   // Only live accesses select
    sel[SEL_TIMER] = bus.en & hit_timer;
    sel[SEL_DACX]  = bus.en & hit_dacx;
    sel[SEL_DACY]  = bus.en & hit_dacy;
  end

endmodule

`default_nettype wire

/* gpio/msp430_gpio.sv */
/*
 * Digital I/O
 * Port 1 switch inputs with edge interrupt, Port 2 LED outputs
 */
`timescale 1ns/10ps
`default_nettype none

module msp430_gpio (
  input  logic                      mclk,
  input  logic                      rst_n,
  per_if.slave                      bus,
  input  logic                      sel,
  input  msp430_dev_pkg::port_t     p1_din,
  output msp430_per_pkg::per_data_t rdata,
  output logic                      irq_port1,
  output logic [1:0]                led
);
  import msp430_per_pkg::*;
  import msp430_dev_pkg::*;

  reg_off_t  off;
  logic      wr, rd;
  per_data_t wdata;
  port_t     p1_meta, p1_sync, p1_last;
  port_t     p1_rise;
  port_t     p1ie, p1ifg, p2out, p2dir;

  assign off   = reg_off_t'(bus.addr & (GPIO_SPAN - 1));  // Block is span aligned
  assign wr    = sel & (|bus.we);
  assign rd    = sel & ~(|bus.we);
  assign wdata = byte_merge('0, bus.din, bus.we);         // Byte regs take low lane

  // ================================================
  // Input sync and edge detect
  // ================================================
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      p1_meta <= '0;
      p1_sync <= '0;
      p1_last <= '0;
    end else begin
      p1_meta <= p1_din;   // First stage
      p1_sync <= p1_meta;  // Second stage
      p1_last <= p1_sync;  // Previous value for edges
    end
  end

  assign p1_rise = p1_sync & ~p1_last;

  // Control registers
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      p1ie  <= '0;
      p1ifg <= '0;
      p2out <= '0;
      p2dir <= '0;
    end else begin
      if (wr && off == P1IE)  p1ie  <= wdata[7:0];
      if (wr && off == P2OUT) p2out <= wdata[7:0];
      if (wr && off == P2DIR) p2dir <= wdata[7:0];
      if (wr && off == P1IFG) p1ifg <= wdata[7:0];  // Write 0 to clear
      else                    p1ifg <= p1ifg | p1_rise;
    end
  end

  assign irq_port1 = |(p1ifg & p1ie);
  assign led       = p2out[1:0] & p2dir[1:0];  // Lit only when driven

  always_comb begin
    rdata = '0;
    if (rd) begin
      case (off)
        P1IN:    rdata = {8'h00, p1_sync};
        P1IE:    rdata = {8'h00, p1ie};
        P1IFG:   rdata = {8'h00, p1ifg};
        P2OUT:   rdata = {8'h00, p2out};
        P2DIR:   rdata = {8'h00, p2dir};
        default: rdata = '0;  // Unmapped words
      endcase
    end
  end

endmodule

`default_nettype wire

/* timer/msp430_timer.sv */
/*
 * Timer A, up mode only
 * TAR counts to TACCR0 each mclk and flags CCIFG on wrap
 */
`timescale 1ns/10ps
`default_nettype none

module msp430_timer (
  input  logic                      mclk,
  input  logic                      rst_n,
  per_if.slave                      bus,
  input  logic                      sel,
  output msp430_per_pkg::per_data_t rdata,
  output logic                      irq_ta0,
  output logic                      irq_ta1
);
  import msp430_per_pkg::*;
  import msp430_dev_pkg::*;

  reg_off_t  off;
  logic      wr, rd;
  logic      wr_tactl, wr_cctl, wr_tar, wr_ccr0;
  logic      hold, run, at_top;
  per_data_t tactl, tar, taccr0, taccctl0;
  logic      ccie, ccifg;

  assign off      = reg_off_t'(bus.addr & (TIMER_SPAN - 1));
  assign wr       = sel & (|bus.we);
  assign rd       = sel & ~(|bus.we);
  assign wr_tactl = wr && (off == TACTL);
  assign wr_cctl  = wr && (off == TACCTL0);
  assign wr_tar   = wr && (off == TAR);
  assign wr_ccr0  = wr && (off == TACCR0);
  assign hold     = wr_cctl | wr_tar | wr_ccr0;  // Bus write wins this cycle
  assign run      = tactl[TACTL_RUN];
  assign at_top   = (tar == taccr0);

  always_comb begin
    taccctl0                = '0;  // Only CCIE and CCIFG are kept
    taccctl0[TACCTL0_CCIE]  = ccie;
    taccctl0[TACCTL0_CCIFG] = ccifg;
  end

  // ================================================
  // Counter and compare
  // ================================================
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      tactl  <= '0;
      taccr0 <= '0;
      tar    <= '0;
    end else begin
      if (wr_tactl) tactl  <= byte_merge(tactl, bus.din, bus.we);
      if (wr_ccr0)  taccr0 <= byte_merge(taccr0, bus.din, bus.we);
      if (wr_tar)   tar    <= byte_merge(tar, bus.din, bus.we);
      else if (run && !hold) tar <= at_top ? '0 : tar + 1'b1;  // Up mode
    end
  end

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      ccie  <= 1'b0;
      ccifg <= 1'b0;
    end else if (wr_cctl) begin
      ccie  <= bus.we[0] ? bus.din[TACCTL0_CCIE]  : ccie;   // Both bits in low lane
      ccifg <= bus.we[0] ? bus.din[TACCTL0_CCIFG] : ccifg;
    end else if (run && !hold && at_top) begin
      ccifg <= 1'b1;                                        // Wrap event
    end
  end

  assign irq_ta0 = ccifg & ccie;
  assign irq_ta1 = 1'b0;  // No TAIV sources

  always_comb begin
    rdata = '0;
    if (rd) begin
      case (off)
        TACTL:   rdata = tactl;
        TACCTL0: rdata = taccctl0;
        TAR:     rdata = tar;
        TACCR0:  rdata = taccr0;
        default: rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* dac/msp430_dac_spi.sv */
/*
 * SPI DAC serializer, one channel
 * Shifts a 16-bit word out MSB first inside a sync_n frame
 */
`timescale 1ns/10ps
`default_nettype none

module msp430_dac_spi (
  input  logic                      mclk,
  input  logic                      rst_n,
  per_if.slave                      bus,
  input  logic                      sel,
  output msp430_per_pkg::per_data_t rdata,
  output logic                      din,
  output logic                      sclk,
  output logic                      sync_n
);
  import msp430_per_pkg::*;
  import msp430_dev_pkg::*;

  reg_off_t            off;
  logic                wr_val, rd, load, busy, half_end;
  per_data_t           dac_val, val_wr, stat;
  logic [DAC_BITS-1:0] shreg;
  spi_state_e          state;
  div_cnt_t            div_cnt;
  bit_cnt_t            bit_cnt;

  assign off      = reg_off_t'(bus.addr & (DAC_SPAN - 1));
  assign wr_val   = sel && (|bus.we) && (off == DAC_VAL);
  assign rd       = sel & ~(|bus.we);
  assign val_wr   = byte_merge(dac_val, bus.din, bus.we);
  assign load     = wr_val && (state == IDLE);       // Dropped while busy
  assign busy     = (state != IDLE);
  assign half_end = (div_cnt == div_cnt_t'(SCLK_DIV));

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) dac_val <= '0;
    else if (load) dac_val <= val_wr;  // Last loaded word
  end

  // Shift data, bit below MSB feeds din on each rising sclk
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) shreg <= '0;
    else if (load) shreg <= val_wr;
    else if (state == SHIFT && half_end && !sclk) shreg <= {shreg[DAC_BITS-2:0], 1'b0};
  end

  // ================================================
  // Frame FSM
  // ================================================
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      sync_n  <= 1'b1;
      sclk    <= 1'b0;
      din     <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: if (load) begin
          state   <= SHIFT;
          sync_n  <= 1'b0;                 // Open frame
          sclk    <= 1'b1;
          din     <= val_wr[DAC_BITS-1];   // MSB with first high phase
          div_cnt <= '0;
          bit_cnt <= '0;
        end
        SHIFT: if (half_end) begin
          div_cnt <= '0;
          sclk    <= ~sclk;
          if (sclk) begin                  // Falling edge, DAC samples
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == bit_cnt_t'(DAC_BITS - 1)) state <= DONE;
          end else begin
            din <= shreg[DAC_BITS-2];      // Next bit on rising edge
          end
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
        DONE: begin
          sync_n <= 1'b1;                  // Close frame
          din    <= 1'b0;
          state  <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    stat                = '0;
    stat[DAC_STAT_BUSY] = busy;
  end

  always_comb begin
    rdata = '0;
    if (rd) begin
      case (off)
        DAC_VAL:  rdata = dac_val;
        DAC_STAT: rdata = stat;
        default:  rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/per_result.sv */
/*
 * Result stage
 * Registered read-data combine and interrupt vector
 */
`timescale 1ns/10ps
`default_nettype none

module per_result (
  input  logic                      mclk,
  input  logic                      rst_n,
  input  msp430_per_pkg::per_data_t gpio_rdata,
  input  msp430_per_pkg::per_data_t timer_rdata,
  input  msp430_per_pkg::per_data_t dacx_rdata,
  input  msp430_per_pkg::per_data_t dacy_rdata,
  input  logic                      irq_port1,
  input  logic                      irq_ta0,
  input  logic                      irq_ta1,
  output msp430_per_pkg::per_data_t per_dout,
  output msp430_dev_pkg::irq_vec_t  irq
);
  import msp430_dev_pkg::*;

  irq_vec_t irq_nxt;

  always_comb begin
    irq_nxt            = '0;         // Unused vectors stay low
    irq_nxt[IRQ_PORT1] = irq_port1;
    irq_nxt[IRQ_TA1]   = irq_ta1;
    irq_nxt[IRQ_TA0]   = irq_ta0;
  end

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      per_dout <= '0;
      irq      <= '0;
    end else begin
      per_dout <= gpio_rdata | timer_rdata | dacx_rdata | dacy_rdata;  // Unselected are 0
      irq      <= irq_nxt;
    end
  end

endmodule

`default_nettype wire

/* source/msp430_periph_top.sv */
/*
 * MSP430 peripheral subsystem top
 * GPIO, Timer A and two SPI DACs on the peripheral bus
 */
`timescale 1ns/10ps
`default_nettype none

module msp430_periph_top (
  input  logic                      mclk,
  input  logic                      rst_n,
  input  msp430_per_pkg::per_addr_t per_addr,
  input  msp430_per_pkg::per_data_t per_din,
  input  msp430_per_pkg::per_we_t   per_we,
  input  logic                      per_en,
  input  logic [3:0]                switch,
  output msp430_per_pkg::per_data_t per_dout,
  output msp430_dev_pkg::irq_vec_t  irq,
  output logic [1:0]                led,
  output logic                      din_x,
  output logic                      sclk_x,
  output logic                      sync_n_x,
  output logic                      din_y,
  output logic                      sclk_y,
  output logic                      sync_n_y
);
  import msp430_per_pkg::*;
  import msp430_dev_pkg::*;

  per_if     bus ();
  blk_sel_t  sel;
  port_t     p1_din;
  per_data_t gpio_rdata, timer_rdata, dacx_rdata, dacy_rdata;
  logic      irq_port1, irq_ta0, irq_ta1;

  // Pins drive the bus from the ctrl side
  assign bus.addr = per_addr;
  assign bus.din  = per_din;
  assign bus.we   = per_we;
  assign bus.en   = per_en;

  assign p1_din = {4'h0, switch};  // Switches on P1.3..0

  // ================================================
  // Decode and peripherals
  // ================================================
  per_decode i_decode (.bus(bus), .sel(sel));

  msp430_gpio i_gpio (
    .mclk(mclk), .rst_n(rst_n), .bus(bus), .sel(sel[SEL_GPIO]), .p1_din(p1_din),
    .rdata(gpio_rdata), .irq_port1(irq_port1), .led(led)
  );

  msp430_timer i_timer (
    .mclk(mclk), .rst_n(rst_n), .bus(bus), .sel(sel[SEL_TIMER]),
    .rdata(timer_rdata), .irq_ta0(irq_ta0), .irq_ta1(irq_ta1)
  );

  msp430_dac_spi i_dac_x (
    .mclk(mclk), .rst_n(rst_n), .bus(bus), .sel(sel[SEL_DACX]),
    .rdata(dacx_rdata), .din(din_x), .sclk(sclk_x), .sync_n(sync_n_x)
  );

  msp430_dac_spi i_dac_y (
    .mclk(mclk), .rst_n(rst_n), .bus(bus), .sel(sel[SEL_DACY]),
    .rdata(dacy_rdata), .din(din_y), .sclk(sclk_y), .sync_n(sync_n_y)
  );

  per_result i_result (
    .mclk(mclk), .rst_n(rst_n),
    .gpio_rdata(gpio_rdata), .timer_rdata(timer_rdata),
    .dacx_rdata(dacx_rdata), .dacy_rdata(dacy_rdata),
    .irq_port1(irq_port1), .irq_ta0(irq_ta0), .irq_ta1(irq_ta1),
    .per_dout(per_dout), .irq(irq)
  );

endmodule

`default_nettype wire

/* tb/tb_periph.sv */
/*
 * Testbench for the MSP430 peripheral subsystem
 * Drives the bus, switches and checks results with concurrent assertions
 */
`timescale 1ns/10ps
`default_nettype none

module tb_periph;
  import msp430_per_pkg::*;
  import msp430_dev_pkg::*;

  localparam irq_vec_t IRQ_USED = irq_vec_t'((1 << IRQ_PORT1) | (1 << IRQ_TA0));

  logic      mclk = 1'b0;
  logic      rst_n;
  per_addr_t per_addr;
  per_data_t per_din;
  per_we_t   per_we;
  logic      per_en;
  logic [3:0] switch;
  per_data_t per_dout;
  irq_vec_t  irq;
  logic [1:0] led;
  logic      din_x, sclk_x, sync_n_x, din_y, sclk_y, sync_n_y;

  // Checker state, driven from the stimulus process
  logic      rst_chk, rd_chk, le_chk, p1_off_chk, ta_off_chk, dac_chk, dac_ch;
  per_data_t rd_exp, le_max, dac_exp;
  string     rd_name;
  port_t     p2out_m, p2dir_m;             // Port 2 model
  logic [31:0] rng_state;

  // Frame capture, owned by the capture block
  per_data_t cap = '0;
  int        cap_cnt = 0;
  logic      cur_sclk, cur_din, cur_sync;
  logic      last_sclk = 1'b0;
  logic      last_sync = 1'b1;

  msp430_periph_top i_dut (
    .mclk(mclk), .rst_n(rst_n), .per_addr(per_addr), .per_din(per_din),
    .per_we(per_we), .per_en(per_en), .switch(switch),
    .per_dout(per_dout), .irq(irq), .led(led),
    .din_x(din_x), .sclk_x(sclk_x), .sync_n_x(sync_n_x),
    .din_y(din_y), .sclk_y(sclk_y), .sync_n_y(sync_n_y)
  );

  always #4 mclk = ~mclk;  // 8 ns period

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic logic [15:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;  // LCG step
    return rng_state[30:15];
  endfunction

  function automatic per_addr_t reg_addr(input per_addr_t base, input reg_off_t off);
    return base + per_addr_t'(off);
  endfunction

  // ================================================
  // Assertions
  // ================================================
  a_reset: assert property (@(posedge mclk) rst_chk |->
      (per_dout == '0 && irq == '0 && led == 2'b00 && sync_n_x && sync_n_y))
    else report_error($sformatf("FAILED reset expected dout 0 irq 0 led 0 sync 11 %s",
      $sformatf("actual dout %h irq %h led %0d sync %b%b", $sampled(per_dout),
      $sampled(irq), $sampled(led), $sampled(sync_n_x), $sampled(sync_n_y))));

  a_read_eq: assert property (@(posedge mclk) disable iff (!rst_n)
      rd_chk |-> per_dout == rd_exp)
    else report_error($sformatf("FAILED %s expected %h actual %h",
      rd_name, rd_exp, $sampled(per_dout)));

  a_read_le: assert property (@(posedge mclk) disable iff (!rst_n)
      le_chk |-> per_dout <= le_max)
    else report_error($sformatf("FAILED %s expected <= %h actual %h",
      rd_name, le_max, $sampled(per_dout)));

  a_led: assert property (@(posedge mclk) disable iff (!rst_n)
      led == (p2out_m[1:0] & p2dir_m[1:0]))
    else report_error($sformatf("FAILED led expected %b actual %b",
      p2out_m[1:0] & p2dir_m[1:0], $sampled(led)));

  a_irq_unused: assert property (@(posedge mclk) disable iff (!rst_n)
      (irq & ~IRQ_USED) == '0)                       // Includes TA1 on bit 4
    else report_error($sformatf("FAILED irq_unused expected %h actual %h",
      irq_vec_t'(0), $sampled(irq) & ~IRQ_USED));

  a_p1_off: assert property (@(posedge mclk) disable iff (!rst_n)
      p1_off_chk |-> !irq[IRQ_PORT1])
    else report_error("FAILED port1_off expected 0 actual 1");

  a_ta_off: assert property (@(posedge mclk) disable iff (!rst_n)
      ta_off_chk |-> !irq[IRQ_TA0])
    else report_error("FAILED timer_clear expected 0 actual 1");

  a_dac_frame: assert property (@(posedge mclk) disable iff (!rst_n)
      dac_chk |-> (cap == dac_exp && cap_cnt == DAC_BITS))
    else report_error($sformatf("FAILED dac_frame expected %0d bits %h actual %0d bits %h",
      DAC_BITS, dac_exp, cap_cnt, cap));

  a_dac_quiet: assert property (@(posedge mclk) disable iff (!rst_n)
      (dac_ch ? sync_n_x : sync_n_y))               // Other channel stays idle
    else report_error("FAILED dac_quiet expected sync_n 1 actual 0");

  // Rebuild the DAC word on falling sclk inside the frame
  always @(negedge mclk) begin
    cur_sclk = dac_ch ? sclk_y : sclk_x;
    cur_din  = dac_ch ? din_y : din_x;
    cur_sync = dac_ch ? sync_n_y : sync_n_x;
    if (last_sync && !cur_sync) begin               // Frame opens
      cap     = '0;
      cap_cnt = 0;
    end else if (!cur_sync && last_sclk && !cur_sclk) begin
      cap     = {cap[DAC_BITS-2:0], cur_din};       // MSB first
      cap_cnt = cap_cnt + 1;
    end
    last_sclk = cur_sclk;
    last_sync = cur_sync;
  end

  // ================================================
  // Bus tasks
  // ================================================
  task automatic write_bus(input per_addr_t addr, input per_data_t data, input per_we_t we);
    @(negedge mclk);
    per_addr = addr;
    per_din  = data;
    per_we   = we;
    per_en   = 1'b1;
    @(negedge mclk);
    per_en = 1'b0;
    per_we = '0;
  endtask

  // Data shows on per_dout in the cycle after the request
  task automatic read_bus(input string name, input per_addr_t addr, input per_data_t exp,
                          input logic le);
    @(negedge mclk);
    per_addr = addr;
    per_we   = '0;
    per_en   = 1'b1;
    @(negedge mclk);
    per_en  = 1'b0;
    rd_name = name;
    if (le) begin
      le_max = exp;
      le_chk = 1'b1;
    end else begin
      rd_exp = exp;
      rd_chk = 1'b1;
    end
    @(negedge mclk);
    rd_chk = 1'b0;
    le_chk = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge mclk);
  endtask

  task automatic wait_irq(input int slot, input string name, input int limit);
    int n;
    n = 0;
    while (!irq[slot] && n < limit) begin
      @(negedge mclk);
      n++;
    end
    if (!irq[slot])
      report_error($sformatf("Timeout waiting for irq bit %0d in test %s", slot, name));
  endtask

  task automatic wait_frame_end(input int limit);
    int n;
    n = 0;
    while (!(dac_ch ? sync_n_y : sync_n_x) && n < limit) begin
      @(negedge mclk);
      n++;
    end
    if (!(dac_ch ? sync_n_y : sync_n_x))
      report_error("Timeout waiting for the DAC frame to end");
  endtask

  // ================================================
  // Tests
  // ================================================
  task automatic reg_access();
    per_data_t v;
    read_bus("tactl_reset", reg_addr(TIMER_BASE, TACTL), '0, 1'b0);
    read_bus("p2out_reset", reg_addr(GPIO_BASE, P2OUT), '0, 1'b0);
    v = next_rand();
    write_bus(reg_addr(GPIO_BASE, P2OUT), v, 2'b11);
    p2out_m = v[7:0];
    read_bus("p2out_rand", reg_addr(GPIO_BASE, P2OUT), {8'h00, v[7:0]}, 1'b0);
    v = next_rand();
    write_bus(reg_addr(GPIO_BASE, P2DIR), v, 2'b11);
    p2dir_m = v[7:0];
    read_bus("p2dir_rand", reg_addr(GPIO_BASE, P2DIR), {8'h00, v[7:0]}, 1'b0);
    write_bus(reg_addr(TIMER_BASE, TACCR0), 16'hA5C3, 2'b11);
    write_bus(reg_addr(TIMER_BASE, TACCR0), 16'h3C77, 2'b10);  // High lane only
    read_bus("byte_lane", reg_addr(TIMER_BASE, TACCR0), 16'h3CC3, 1'b0);
    read_bus("unmapped_gpio", reg_addr(GPIO_BASE, 4'd3), '0, 1'b0);
    read_bus("unmapped_low", per_addr_t'(14'h0089), '0, 1'b0);  // Low bits alias TACCR0
    read_bus("unmapped_top", per_addr_t'(14'h3FFC), '0, 1'b0);  // Low bits alias P2OUT
  endtask

  task automatic led_patterns();
    per_data_t o, d;
    int i;
    for (i = 0; i < 8; i++) begin
      o = next_rand();
      d = next_rand();
      write_bus(reg_addr(GPIO_BASE, P2OUT), o, 2'b11);
      p2out_m = o[7:0];
      write_bus(reg_addr(GPIO_BASE, P2DIR), d, 2'b11);
      p2dir_m = d[7:0];
      idle(1);
    end
  endtask

  task automatic port1_edges();
    int b;
    b = int'(next_rand() & 16'h0003);
    write_bus(reg_addr(GPIO_BASE, P1IE), 16'h000F, 2'b11);
    switch[b] = 1'b1;
    wait_irq(IRQ_PORT1, "port1_irq", 20);
    read_bus("p1ifg_set", reg_addr(GPIO_BASE, P1IFG), 16'h1 << b, 1'b0);
    write_bus(reg_addr(GPIO_BASE, P1IFG), '0, 2'b11);
    idle(1);                                        // Vector lags by one cycle
    p1_off_chk = 1'b1;
    write_bus(reg_addr(GPIO_BASE, P1IE), '0, 2'b11);
    switch = 4'hF;                                  // Edges on the other bits
    idle(10);
    read_bus("p1ifg_masked", reg_addr(GPIO_BASE, P1IFG), 16'h000F & ~(16'h1 << b), 1'b0);
  endtask

  task automatic timer_wrap();
    per_data_t ccr;
    ccr = 16'd8 + (next_rand() & 16'h001F);
    write_bus(reg_addr(TIMER_BASE, TACCR0), ccr, 2'b11);
    read_bus("taccr0_rand", reg_addr(TIMER_BASE, TACCR0), ccr, 1'b0);
    write_bus(reg_addr(TIMER_BASE, TACCTL0), per_data_t'(1 << TACCTL0_CCIE), 2'b11);
    write_bus(reg_addr(TIMER_BASE, TACTL), per_data_t'(1 << TACTL_RUN), 2'b11);
    wait_irq(IRQ_TA0, "timer_irq", 200);
    write_bus(reg_addr(TIMER_BASE, TACTL), '0, 2'b11);
    read_bus("tar_stopped", reg_addr(TIMER_BASE, TAR), ccr, 1'b1);
    write_bus(reg_addr(TIMER_BASE, TACCTL0), per_data_t'(1 << TACCTL0_CCIE), 2'b11);
    idle(1);
    ta_off_chk = 1'b1;
    idle(4);
  endtask

  task automatic dac_frame(input logic ch);
    per_addr_t base;
    per_data_t w1;
    base    = ch ? DACY_BASE : DACX_BASE;
    dac_ch  = ch;
    w1      = next_rand();
    dac_exp = w1;
    write_bus(reg_addr(base, DAC_VAL), w1, 2'b11);
    read_bus("dac_busy", reg_addr(base, DAC_STAT), per_data_t'(1 << DAC_STAT_BUSY), 1'b0);
    write_bus(reg_addr(base, DAC_VAL), ~w1, 2'b11);  // Ignored mid frame
    wait_frame_end(200);
    dac_chk = 1'b1;
    idle(1);
    dac_chk = 1'b0;
    read_bus("dac_idle", reg_addr(base, DAC_STAT), '0, 1'b0);
    read_bus("dac_val", reg_addr(base, DAC_VAL), w1, 1'b0);
  endtask

  initial begin
    rst_n      = 1'b0;
    per_addr   = '0;
    per_din    = '0;
    per_we     = '0;
    per_en     = 1'b0;
    switch     = 4'h0;
    rst_chk    = 1'b0;
    rd_chk     = 1'b0;
    le_chk     = 1'b0;
    p1_off_chk = 1'b0;
    ta_off_chk = 1'b0;
    dac_chk    = 1'b0;
    dac_ch     = 1'b0;
    rd_exp     = '0;
    le_max     = '0;
    dac_exp    = '0;
    rd_name    = "";
    p2out_m    = '0;
    p2dir_m    = '0;
    rng_state  = 32'd31;                            // Seed
    repeat (16) @(negedge mclk);
    rst_n   = 1'b1;
    rst_chk = 1'b1;
    idle(1);
    rst_chk = 1'b0;
    reg_access();
    led_patterns();
    port1_edges();
    timer_wrap();
    dac_frame(1'b0);
    dac_frame(1'b1);
    idle(4);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
common/msp430_per_pkg.sv
common/msp430_dev_pkg.sv
common/per_if.sv
source/per_decode.sv
gpio/msp430_gpio.sv
timer/msp430_timer.sv
dac/msp430_dac_spi.sv
source/per_result.sv
source/msp430_periph_top.sv
tb/tb_periph.sv

/* run.sh */
#!/bin/sh
# Build and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_periph -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_periph 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
